// File: Bender.yml
package:
  name: aes_clp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/aes_clp_pkg.sv
      - rtl/aes_clp_regs.sv
      - rtl/kv_read_client.sv
      - rtl/entropy_prng.sv
      - rtl/aes_clp_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/aes_clp_assertions.sv
      - verification/aes_clp_tb.sv

// File: build.f
+incdir+include
rtl/aes_clp_pkg.sv
rtl/aes_clp_regs.sv
rtl/kv_read_client.sv
rtl/entropy_prng.sv
rtl/aes_clp_top.sv
verification/aes_clp_assertions.sv
verification/aes_clp_tb.sv

// File: include/aes_clp_params.svh
`ifndef AES_CLP_PARAMS_SVH
`define AES_CLP_PARAMS_SVH

// ==================================================
// Register window word addresses
// ==================================================
`define AES_CLP_NAME_ADDR    6'd0
`define AES_CLP_VERSION_ADDR 6'd1
`define KV_RD_CTRL_ADDR      6'd2
`define KV_RD_STATUS_ADDR    6'd3
// Seeds 0 to 3 follow from here
`define SEED_BASE_ADDR       6'd4

// Read-only identification words
`define AES_CLP_NAME_VAL     32'h4145_5343
`define AES_CLP_VERSION_VAL  32'h0001_0000

// Sizes in 32-bit words
`define KEY_DWORDS 8
`define SEED_WORDS 4

// Key fetch error codes
`define KV_SUCCESS   8'h00
`define KV_READ_FAIL 8'h01

// Generator state x y z w after reset
`define PRNG_RESET_SEED0 32'd123456789
`define PRNG_RESET_SEED1 32'd362436069
`define PRNG_RESET_SEED2 32'd521288629
`define PRNG_RESET_SEED3 32'd88675123

`endif

// File: rtl/aes_clp_pkg.sv
`include "aes_clp_params.svh"

package aes_clp_pkg;

  // ==================================================
  // Vector types
  // ==================================================

  // Host data, vault data, seeds, entropy
  typedef logic [31:0] word_t;

  // Full key as seen by the engine
  typedef logic [`KEY_DWORDS*32-1:0] key_t;

  // Word address in the host window
  typedef logic [5:0] reg_addr_t;

  // Vault slot and dword index within a key
  typedef logic [4:0] kv_entry_t;
  typedef logic [2:0] kv_offset_t;

  // Fetch result code
  typedef logic [7:0] kv_err_t;

  // ==================================================
  // Key fetch FSM
  // ==================================================
  typedef enum logic [1:0] {
    KV_IDLE,
    KV_REQ,
    KV_RELEASE,
    KV_DONE
  } kv_rd_state_e;

endpackage

// File: rtl/aes_clp_regs.sv
`timescale 1ns/1ps
`include "aes_clp_params.svh"

module aes_clp_regs (
  input  logic                                        clk,
  input  logic                                        reset_n,
  // Host port
  input  logic                                        host_req_i,
  input  logic                                        host_we_i,
  input  aes_clp_pkg::reg_addr_t                      host_addr_i,
  input  aes_clp_pkg::word_t                          host_wdata_i,
  output logic                                        host_ack_o,
  output aes_clp_pkg::word_t                          host_rdata_o,
  output logic                                        host_err_o,
  // Engine and key client
  input  logic                                        engine_idle_i,
  input  logic                                        kv_ready_i,
  input  logic                                        kv_done_i,
  input  aes_clp_pkg::kv_err_t                        kv_error_i,
  output logic                                        kv_start_o,
  output aes_clp_pkg::kv_entry_t                      kv_entry_o,
  // Seed words to the generator
  output aes_clp_pkg::word_t [`SEED_WORDS-1:0]        seed_o,
  output logic                                        seed_load_o
);

  logic                                 host_take;
  logic                                 host_wr;
  logic                                 bad_addr;
  logic                                 ro_addr;
  logic                                 acc_err;
  logic                                 ctrl_wr;
  logic                                 valid_q;
  aes_clp_pkg::word_t                   rdata_d;
  aes_clp_pkg::kv_entry_t               entry_q;
  aes_clp_pkg::word_t [`SEED_WORDS-1:0] seed_q;
  logic [`SEED_WORDS-1:0]               chunk_q;
  logic [`SEED_WORDS-1:0]               chunk_wr;

  // ==================================================
  // Host handshake and decode
  // ==================================================

  // New access accepted on the edge that raises ack
  assign host_take = host_req_i && !host_ack_o;
  assign host_wr   = host_take && host_we_i;

  // Past the last seed word
  assign bad_addr = host_addr_i > (`SEED_BASE_ADDR + 6'd3);
  // Identification and status are read only
  assign ro_addr  = (host_addr_i == `AES_CLP_NAME_ADDR) ||
                    (host_addr_i == `AES_CLP_VERSION_ADDR) ||
                    (host_addr_i == `KV_RD_STATUS_ADDR);
  assign acc_err  = bad_addr || (host_we_i && ro_addr);

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (host_addr_i)
      `AES_CLP_NAME_ADDR:    rdata_d = `AES_CLP_NAME_VAL;
      `AES_CLP_VERSION_ADDR: rdata_d = `AES_CLP_VERSION_VAL;
      // read_en always reads back as zero
      `KV_RD_CTRL_ADDR:      rdata_d = {26'd0, entry_q, 1'b0};
      `KV_RD_STATUS_ADDR:    rdata_d = {22'd0, kv_error_i, valid_q, kv_ready_i};
      default: begin
        for (int i = 0; i < `SEED_WORDS; i++) begin
          if (host_addr_i == aes_clp_pkg::reg_addr_t'(`SEED_BASE_ADDR + i)) begin
            rdata_d = seed_q[i];
          end
        end
      end
    endcase
  end

  // Ack rises on accept and falls once req is seen low
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      host_ack_o   <= 1'b0;
      host_rdata_o <= '0;
      host_err_o   <= 1'b0;
    end else if (host_take) begin
      host_ack_o   <= 1'b1;
      host_rdata_o <= rdata_d;
      host_err_o   <= acc_err;
    end else if (host_ack_o && !host_req_i) begin
      host_ack_o <= 1'b0;
    end
  end

  // ==================================================
  // Key read control and status
  // ==================================================

  // Write lock passes control writes only while engine idle and client ready
  assign ctrl_wr = host_wr && (host_addr_i == `KV_RD_CTRL_ADDR) &&
                   engine_idle_i && kv_ready_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      kv_start_o <= 1'b0;
      entry_q    <= '0;
    end else begin
      // One-cycle start pulse from read_en
      kv_start_o <= ctrl_wr && host_wdata_i[0];
      if (ctrl_wr) begin
        entry_q <= host_wdata_i[5:1];
      end
    end
  end

  assign kv_entry_o = entry_q;

  // Valid cleared by start and set by fetch end
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
    end else if (kv_start_o) begin
      valid_q <= 1'b0;
    end else if (kv_done_i) begin
      valid_q <= 1'b1;
    end
  end

  // ==================================================
  // Seed registers and chunk tracking
  // ==================================================
  always_comb begin
    for (int i = 0; i < `SEED_WORDS; i++) begin
      chunk_wr[i] = host_wr &&
                    (host_addr_i == aes_clp_pkg::reg_addr_t'(`SEED_BASE_ADDR + i));
    end
  end

  // Reseed once every chunk has been written
  assign seed_load_o = &chunk_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_q  <= '0;
      chunk_q <= '0;
    end else begin
      for (int i = 0; i < `SEED_WORDS; i++) begin
        if (chunk_wr[i]) begin
          seed_q[i] <= host_wdata_i;
        end
      end
      // Tracking restarts after a reseed
      chunk_q <= seed_load_o ? '0 : (chunk_q | chunk_wr);
    end
  end

  assign seed_o = seed_q;

endmodule

// File: rtl/aes_clp_top.sv
`timescale 1ns/1ps
`include "aes_clp_params.svh"

module aes_clp_top (
  input  logic                    clk,
  input  logic                    reset_n,
  // Host register window
  input  logic                    host_req_i,
  input  logic                    host_we_i,
  input  aes_clp_pkg::reg_addr_t  host_addr_i,
  input  aes_clp_pkg::word_t      host_wdata_i,
  output logic                    host_ack_o,
  output aes_clp_pkg::word_t      host_rdata_o,
  output logic                    host_err_o,
  // Key vault
  output logic                    kv_req_o,
  output aes_clp_pkg::kv_entry_t  kv_entry_o,
  output aes_clp_pkg::kv_offset_t kv_offset_o,
  input  logic                    kv_ack_i,
  input  aes_clp_pkg::word_t      kv_data_i,
  input  logic                    kv_err_i,
  // Engine side
  input  logic                    engine_idle_i,
  output aes_clp_pkg::key_t       key_o,
  output logic                    key_valid_o,
  input  logic                    ent_req_i,
  output logic                    ent_ack_o,
  output aes_clp_pkg::word_t      ent_data_o
);

  logic                                 kv_start;
  aes_clp_pkg::kv_entry_t               ctrl_entry;
  logic                                 kv_ready;
  logic                                 kv_done;
  aes_clp_pkg::kv_err_t                 kv_error;
  aes_clp_pkg::word_t [`SEED_WORDS-1:0] seed;
  logic                                 seed_load;

  // ==================================================
  // Register file
  // ==================================================
  aes_clp_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_ack_o    (host_ack_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .engine_idle_i (engine_idle_i),
    .kv_ready_i    (kv_ready),
    .kv_done_i     (kv_done),
    .kv_error_i    (kv_error),
    .kv_start_o    (kv_start),
    .kv_entry_o    (ctrl_entry),
    .seed_o        (seed),
    .seed_load_o   (seed_load)
  );

  // Key fetch from the vault
  kv_read_client u_kv_client (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (kv_start),
    .entry_i     (ctrl_entry),
    .kv_req_o    (kv_req_o),
    .kv_entry_o  (kv_entry_o),
    .kv_offset_o (kv_offset_o),
    .kv_ack_i    (kv_ack_i),
    .kv_data_i   (kv_data_i),
    .kv_err_i    (kv_err_i),
    .ready_o     (kv_ready),
    .done_o      (kv_done),
    .error_o     (kv_error),
    .key_o       (key_o),
    .key_valid_o (key_valid_o)
  );

  // Entropy for the engine
  entropy_prng u_prng (
    .clk         (clk),
    .reset_n     (reset_n),
    .seed_i      (seed),
    .seed_load_i (seed_load),
    .ent_req_i   (ent_req_i),
    .ent_ack_o   (ent_ack_o),
    .ent_data_o  (ent_data_o)
  );

endmodule

// File: rtl/entropy_prng.sv
`timescale 1ns/1ps
`include "aes_clp_params.svh"

module entropy_prng (
  input  logic                                 clk,
  input  logic                                 reset_n,
  // Reseed from the register file
  input  aes_clp_pkg::word_t [`SEED_WORDS-1:0] seed_i,
  input  logic                                 seed_load_i,
  // Entropy port
  input  logic                                 ent_req_i,
  output logic                                 ent_ack_o,
  output aes_clp_pkg::word_t                   ent_data_o
);

  aes_clp_pkg::word_t x_q;
  aes_clp_pkg::word_t y_q;
  aes_clp_pkg::word_t z_q;
  aes_clp_pkg::word_t w_q;
  aes_clp_pkg::word_t t;
  aes_clp_pkg::word_t w_next;
  logic               step;

  // One step per accepted request
  assign step = ent_req_i && !ent_ack_o;

  // Marsaglia xorshift128
  assign t      = x_q ^ (x_q << 11);
  assign w_next = w_q ^ (w_q >> 19) ^ t ^ (t >> 8);

  // Ack follows req by one edge and stays up while req held
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ent_ack_o <= 1'b0;
    end else if (step) begin
      ent_ack_o <= 1'b1;
    end else if (ent_ack_o && !ent_req_i) begin
      ent_ack_o <= 1'b0;
    end
  end

  // Reseed wins over a step
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      x_q <= `PRNG_RESET_SEED0;
      y_q <= `PRNG_RESET_SEED1;
      z_q <= `PRNG_RESET_SEED2;
      w_q <= `PRNG_RESET_SEED3;
    end else if (seed_load_i) begin
      x_q <= seed_i[0];
      y_q <= seed_i[1];
      z_q <= seed_i[2];
      w_q <= seed_i[3];
    end else if (step) begin
      x_q <= y_q;
      y_q <= z_q;
      z_q <= w_q;
      w_q <= w_next;
    end
  end

  // Newest word
  assign ent_data_o = w_q;

endmodule

// File: rtl/kv_read_client.sv
`timescale 1ns/1ps
`include "aes_clp_params.svh"

module kv_read_client (
  input  logic                       clk,
  input  logic                       reset_n,
  // Control from the register file
  input  logic                       start_i,
  input  aes_clp_pkg::kv_entry_t     entry_i,
  // Key vault port
  output logic                       kv_req_o,
  output aes_clp_pkg::kv_entry_t     kv_entry_o,
  output aes_clp_pkg::kv_offset_t    kv_offset_o,
  input  logic                       kv_ack_i,
  input  aes_clp_pkg::word_t         kv_data_i,
  input  logic                       kv_err_i,
  // Status
  output logic                       ready_o,
  output logic                       done_o,
  output aes_clp_pkg::kv_err_t       error_o,
  // Key to the engine
  output aes_clp_pkg::key_t          key_o,
  output logic                       key_valid_o
);

  aes_clp_pkg::kv_rd_state_e            state_q;
  aes_clp_pkg::kv_entry_t               entry_q;
  aes_clp_pkg::kv_offset_t              offset_q;
  aes_clp_pkg::word_t [`KEY_DWORDS-1:0] key_store;
  logic                                 fail_q;
  logic                                 start_go;
  logic                                 word_take;
  logic                                 last_word;

  // Starts only honoured from idle
  assign start_go  = start_i && (state_q == aes_clp_pkg::KV_IDLE);
  assign word_take = (state_q == aes_clp_pkg::KV_REQ) && kv_ack_i;
  assign last_word = offset_q == aes_clp_pkg::kv_offset_t'(`KEY_DWORDS - 1);

  // ==================================================
  // Fetch FSM with one four-phase read per dword
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= aes_clp_pkg::KV_IDLE;
      entry_q  <= '0;
      offset_q <= '0;
      fail_q   <= 1'b0;
    end else begin
      case (state_q)
        aes_clp_pkg::KV_IDLE: begin
          if (start_go) begin
            entry_q  <= entry_i;
            offset_q <= '0;
            fail_q   <= 1'b0;
            state_q  <= aes_clp_pkg::KV_REQ;
          end
        end
        aes_clp_pkg::KV_REQ: begin
          // Capture happens here and req drops next cycle
          if (kv_ack_i) begin
            fail_q  <= kv_err_i;
            state_q <= aes_clp_pkg::KV_RELEASE;
          end
        end
        aes_clp_pkg::KV_RELEASE: begin
          // Wait for vault to drop ack
          if (!kv_ack_i) begin
            if (fail_q || last_word) begin
              state_q <= aes_clp_pkg::KV_DONE;
            end else begin
              offset_q <= offset_q + 1'b1;
              state_q  <= aes_clp_pkg::KV_REQ;
            end
          end
        end
        aes_clp_pkg::KV_DONE: state_q <= aes_clp_pkg::KV_IDLE;
        default:              state_q <= aes_clp_pkg::KV_IDLE;
      endcase
    end
  end

  assign kv_req_o    = state_q == aes_clp_pkg::KV_REQ;
  assign kv_entry_o  = entry_q;
  assign kv_offset_o = offset_q;
  assign ready_o     = state_q == aes_clp_pkg::KV_IDLE;
  assign done_o      = state_q == aes_clp_pkg::KV_DONE;

  // Byte swap each vault word into engine order
  always_ff @(posedge clk) begin
    if (word_take) begin
      key_store[offset_q] <= {kv_data_i[7:0], kv_data_i[15:8],
                              kv_data_i[23:16], kv_data_i[31:24]};
    end
  end

  // ==================================================
  // Key output and result code
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      error_o     <= `KV_SUCCESS;
      key_valid_o <= 1'b0;
      key_o       <= '0;
    end else if (start_go) begin
      // New fetch drops the old key
      error_o     <= `KV_SUCCESS;
      key_valid_o <= 1'b0;
      key_o       <= '0;
    end else if (done_o) begin
      if (fail_q) begin
        error_o     <= `KV_READ_FAIL;
        key_valid_o <= 1'b0;
        key_o       <= '0;
      end else begin
        error_o     <= `KV_SUCCESS;
        key_valid_o <= 1'b1;
        key_o       <= key_store;
      end
    end
  end

endmodule

// File: verification/aes_clp_assertions.sv
`timescale 1ns/1ps

module aes_clp_assertions (
  input logic                    clk,
  input logic                    reset_n,
  input logic                    host_req_i,
  input logic                    host_ack_i,
  input logic                    kv_req_i,
  input logic                    kv_ack_i,
  input aes_clp_pkg::kv_entry_t  kv_entry_i,
  input aes_clp_pkg::kv_offset_t kv_offset_i,
  input logic                    ent_req_i,
  input logic                    ent_ack_i,
  input logic                    key_valid_i,
  input logic                    kv_ready_i
);

  // Failures so far
  int fail_count = 0;

  task automatic record_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // ==================================================
  // DUT as responder on host and entropy ports
  // ==================================================
  property ack_follows_req(req, ack);
    @(posedge clk) disable iff (!reset_n) req && !ack |=> ack;
  endproperty

  property ack_follows_release(req, ack);
    @(posedge clk) disable iff (!reset_n) !req |=> !ack;
  endproperty

  host_rise: assert property (ack_follows_req(host_req_i, host_ack_i))
    else record_failure("host ack missed a request");
  host_fall: assert property (ack_follows_release(host_req_i, host_ack_i))
    else record_failure("host ack held without a request");
  ent_rise: assert property (ack_follows_req(ent_req_i, ent_ack_i))
    else record_failure("entropy ack missed a request");
  ent_fall: assert property (ack_follows_release(ent_req_i, ent_ack_i))
    else record_failure("entropy ack held without a request");

  // ==================================================
  // DUT as requester on the key vault port
  // ==================================================
  kv_hold: assert property (@(posedge clk) disable iff (!reset_n)
    kv_req_i && !kv_ack_i |=> kv_req_i) else record_failure("vault req dropped early");
  kv_drop: assert property (@(posedge clk) disable iff (!reset_n)
    kv_req_i && kv_ack_i |=> !kv_req_i) else record_failure("vault req held after ack");
  kv_wait: assert property (@(posedge clk) disable iff (!reset_n)
    !kv_req_i && kv_ack_i |=> !kv_req_i) else record_failure("vault req before ack fell");
  // Entry and offset frozen for a whole request
  kv_stable: assert property (@(posedge clk) disable iff (!reset_n)
    kv_req_i && $past(kv_req_i) |-> $stable(kv_entry_i) && $stable(kv_offset_i))
    else record_failure("vault entry or offset moved under req");

  key_ready: assert property (@(posedge clk) disable iff (!reset_n)
    key_valid_i |-> kv_ready_i) else record_failure("key valid while client busy");

endmodule

bind aes_clp_top aes_clp_assertions u_assertions (
  .clk         (clk),
  .reset_n     (reset_n),
  .host_req_i  (host_req_i),
  .host_ack_i  (host_ack_o),
  .kv_req_i    (kv_req_o),
  .kv_ack_i    (kv_ack_i),
  .kv_entry_i  (kv_entry_o),
  .kv_offset_i (kv_offset_o),
  .ent_req_i   (ent_req_i),
  .ent_ack_i   (ent_ack_o),
  .key_valid_i (key_valid_o),
  .kv_ready_i  (kv_ready)
);

// File: verification/aes_clp_tb.sv
`timescale 1ns/1ps
`include "aes_clp_params.svh"

module aes_clp_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int ENT_DRAWS    = 24;
  localparam int FETCH_ROUNDS = 4;
  // Cycle budgets per test
  localparam int REG_BUDGET   = 20 * 8;
  localparam int ENT_BUDGET   = 3 * ENT_DRAWS * 14 + 10 * 8;
  localparam int FETCH_BUDGET = (FETCH_ROUNDS + 3) * 160;
  localparam int LOCK_BUDGET  = 20 + 6 * 8;
  localparam int RUN_BUDGET   = REG_BUDGET + ENT_BUDGET + FETCH_BUDGET + LOCK_BUDGET;

  logic                    clk;
  logic                    reset_n;
  logic                    host_req_i;
  logic                    host_we_i;
  aes_clp_pkg::reg_addr_t  host_addr_i;
  aes_clp_pkg::word_t      host_wdata_i;
  logic                    host_ack_o;
  aes_clp_pkg::word_t      host_rdata_o;
  logic                    host_err_o;
  logic                    kv_req_o;
  aes_clp_pkg::kv_entry_t  kv_entry_o;
  aes_clp_pkg::kv_offset_t kv_offset_o;
  logic                    kv_ack_i;
  aes_clp_pkg::word_t      kv_data_i;
  logic                    kv_err_i;
  logic                    engine_idle_i;
  aes_clp_pkg::key_t       key_o;
  logic                    key_valid_o;
  logic                    ent_req_i;
  logic                    ent_ack_o;
  aes_clp_pkg::word_t      ent_data_o;

  // Stimulus streams
  aes_clp_pkg::word_t rng_state;
  aes_clp_pkg::word_t vault_rng;
  // Vault contents and faulting offset per entry with 8 for none
  aes_clp_pkg::word_t vault_mem [0:32*`KEY_DWORDS-1];
  int                 fault_off [0:31];
  int                 vault_acks;
  // Generator model state
  aes_clp_pkg::word_t m_x;
  aes_clp_pkg::word_t m_y;
  aes_clp_pkg::word_t m_z;
  aes_clp_pkg::word_t m_w;

  aes_clp_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic aes_clp_pkg::word_t xorshift32(input aes_clp_pkg::word_t s);
    aes_clp_pkg::word_t v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic aes_clp_pkg::word_t rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Engine view with each vault word byte reversed
  function automatic aes_clp_pkg::key_t expected_key(input int entry);
    aes_clp_pkg::key_t  k;
    aes_clp_pkg::word_t w;
    for (int n = 0; n < `KEY_DWORDS; n++) begin
      w = vault_mem[entry * `KEY_DWORDS + n];
      k[n*32 +: 32] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return k;
  endfunction

  function automatic int pick_entry(input logic faulty);
    int e;
    do begin
      e = rand_word() % 32;
    end while ((fault_off[e] != 8) != faulty);
    return e;
  endfunction

  // Marsaglia xorshift128 step on the model
  task automatic prng_step();
    aes_clp_pkg::word_t t;
    t   = m_x ^ (m_x << 11);
    m_x = m_y;
    m_y = m_z;
    m_z = m_w;
    m_w = m_w ^ (m_w >> 19) ^ t ^ (t >> 8);
  endtask

  // One four-phase host access started on a falling edge
  task automatic host_access(input logic we, input aes_clp_pkg::reg_addr_t addr,
                             input aes_clp_pkg::word_t wdata,
                             output aes_clp_pkg::word_t rdata, output logic err);
    int n;
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 8) abort_run("Host ack never rose after a request");
    end while (!host_ack_o);
    rdata      = host_rdata_o;
    err        = host_err_o;
    host_req_i = 1'b0;
    host_we_i  = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 8) abort_run("Host ack stayed high after req dropped");
    end while (host_ack_o);
  endtask

  task automatic read_reg(input aes_clp_pkg::reg_addr_t addr, output aes_clp_pkg::word_t data);
    logic err;
    host_access(1'b0, addr, '0, data, err);
    check_value("host_err_o", 0, err);
  endtask

  task automatic write_reg(input aes_clp_pkg::reg_addr_t addr, input aes_clp_pkg::word_t data,
                           input logic exp_err);
    aes_clp_pkg::word_t rdata;
    logic               err;
    host_access(1'b1, addr, data, rdata, err);
    check_value("host_err_o", exp_err, err);
  endtask

  task automatic start_fetch(input int entry);
    engine_idle_i = 1'b1;
    write_reg(`KV_RD_CTRL_ADDR, {26'd0, 5'(entry), 1'b1}, 1'b0);
  endtask

  // Poll status until valid while engine idle wanders
  task automatic wait_fetch_done(output aes_clp_pkg::word_t status);
    int n;
    n = 0;
    do begin
      read_reg(`KV_RD_STATUS_ADDR, status);
      engine_idle_i = (rand_word() & 32'd1) != 0;
      n++;
      if (n > 60) abort_run("Key fetch never reported status valid");
    end while (!status[1]);
  endtask

  // Entropy handshake with random hold and gap
  task automatic ent_draw();
    int n;
    int hold;
    hold = rand_word() % 4;
    ent_req_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 4) abort_run("Entropy ack never rose after a request");
    end while (!ent_ack_o);
    prng_step();
    check_value("ent_data_o", m_w, ent_data_o);
    // Held req keeps ack and data
    repeat (hold) begin
      @(negedge clk);
      check_value("ent_ack_o", 1, ent_ack_o);
      check_value("ent_data_o", m_w, ent_data_o);
    end
    ent_req_i = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 4) abort_run("Entropy ack stayed high after req dropped");
    end while (ent_ack_o);
    repeat (rand_word() % 4) @(negedge clk);
  endtask

  // ==================================================
  // Key vault model
  // ==================================================
  initial begin : vault_model
    int delay;
    kv_ack_i   = 1'b0;
    kv_data_i  = '0;
    kv_err_i   = 1'b0;
    vault_acks = 0;
    delay      = 0;
    forever begin
      @(negedge clk);
      if (kv_req_o && !kv_ack_i) begin
        if (delay == 0) begin
          kv_ack_i  = 1'b1;
          kv_data_i = vault_mem[{kv_entry_o, kv_offset_o}];
          kv_err_i  = fault_off[kv_entry_o] == int'(kv_offset_o);
          vault_acks++;
        end else begin
          delay--;
        end
      end else if (!kv_req_o && kv_ack_i) begin
        kv_ack_i  = 1'b0;
        kv_err_i  = 1'b0;
        vault_rng = xorshift32(vault_rng);
        // Latency for the next word
        delay     = vault_rng % 4;
      end
    end
  end

  initial begin : watchdog
    #(RUN_BUDGET * 4 * CLK_PERIOD);
    abort_run("Timeout, the run went past its cycle budget");
  end

  // Watch the bound assertion failure count
  initial begin : assertion_monitor
    forever begin
      @(negedge clk);
      if (u_dut.u_assertions.fail_count != 0) abort_run("A bound DUT assertion failed");
    end
  end

  // ==================================================
  // Stimulus and checks
  // ==================================================
  initial begin : stimulus
    aes_clp_pkg::word_t rdata;
    aes_clp_pkg::word_t seed_val [`SEED_WORDS];
    logic               err;
    int                 e;
    int                 e2;
    int                 acks0;
    int                 missing;
    int                 first;
    int                 slot;
    reset_n       = 1'b0;
    host_req_i    = 1'b0;
    host_we_i     = 1'b0;
    host_addr_i   = '0;
    host_wdata_i  = '0;
    engine_idle_i = 1'b1;
    ent_req_i     = 1'b0;
    rng_state     = 32'h9ebe_8c56;
    for (int a = 0; a < 32 * `KEY_DWORDS; a++)
      vault_mem[a] = rand_word();
    // About one entry in four faults
    for (int n = 0; n < 32; n++)
      fault_off[n] = (rand_word() % 4 == 0) ? int'(rand_word() % 8) : 8;
    fault_off[0] = 8;
    fault_off[1] = rand_word() % 8;
    vault_rng    = rand_word();
    m_x = `PRNG_RESET_SEED0;
    m_y = `PRNG_RESET_SEED1;
    m_z = `PRNG_RESET_SEED2;
    m_w = `PRNG_RESET_SEED3;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Register window
    check_value("key_valid_o", 0, key_valid_o);
    check_value("kv_req_o", 0, kv_req_o);
    check_value("ent_ack_o", 0, ent_ack_o);
    read_reg(`AES_CLP_NAME_ADDR, rdata);
    check_value("host_rdata_o", `AES_CLP_NAME_VAL, rdata);
    read_reg(`AES_CLP_VERSION_ADDR, rdata);
    check_value("host_rdata_o", `AES_CLP_VERSION_VAL, rdata);
    read_reg(`KV_RD_STATUS_ADDR, rdata);
    check_value("host_rdata_o", {22'd0, `KV_SUCCESS, 1'b0, 1'b1}, rdata);
    // Read-only words refuse writes
    for (int a = 0; a < 4; a++)
      if (a != 2) write_reg(aes_clp_pkg::reg_addr_t'(a), rand_word(), 1'b1);
    repeat (8) begin
      host_access((rand_word() & 32'd1) != 0, aes_clp_pkg::reg_addr_t'(8 + rand_word() % 56),
                  rand_word(), rdata, err);
      check_value("host_err_o", 1, err);
    end
    read_reg(`AES_CLP_NAME_ADDR, rdata);
    check_value("host_rdata_o", `AES_CLP_NAME_VAL, rdata);

    // Entropy before, during and after a seed set
    repeat (ENT_DRAWS) ent_draw();
    for (int i = 0; i < `SEED_WORDS; i++)
      seed_val[i] = rand_word();
    missing = rand_word() % 4;
    first   = rand_word() % 4;
    for (int k = 0; k < `SEED_WORDS; k++) begin
      slot = (first + k) % `SEED_WORDS;
      if (slot != missing)
        write_reg(aes_clp_pkg::reg_addr_t'(`SEED_BASE_ADDR + slot), seed_val[slot], 1'b0);
    end
    repeat (ENT_DRAWS) ent_draw();
    write_reg(aes_clp_pkg::reg_addr_t'(`SEED_BASE_ADDR + missing), seed_val[missing], 1'b0);
    m_x = seed_val[0];
    m_y = seed_val[1];
    m_z = seed_val[2];
    m_w = seed_val[3];
    repeat (ENT_DRAWS) ent_draw();
    for (int i = 0; i < `SEED_WORDS; i++) begin
      read_reg(aes_clp_pkg::reg_addr_t'(`SEED_BASE_ADDR + i), rdata);
      check_value("host_rdata_o", seed_val[i], rdata);
    end

    // Key fetch on clean entries
    for (int r = 0; r < FETCH_ROUNDS; r++) begin
      e     = pick_entry(1'b0);
      acks0 = vault_acks;
      start_fetch(e);
      check_value("key_valid_o", 0, key_valid_o);
      check_value("key_o", 0, key_o);
      read_reg(`KV_RD_STATUS_ADDR, rdata);
      check_value("host_rdata_o[1]", 0, rdata[1]);
      wait_fetch_done(rdata);
      check_value("host_rdata_o", {22'd0, `KV_SUCCESS, 1'b1, 1'b1}, rdata);
      check_value("key_valid_o", 1, key_valid_o);
      check_value("key_o", expected_key(e), key_o);
      check_value("vault reads", 8, vault_acks - acks0);
    end

    // Fetch abort on a faulting word
    e     = pick_entry(1'b1);
    acks0 = vault_acks;
    start_fetch(e);
    wait_fetch_done(rdata);
    check_value("host_rdata_o", {22'd0, `KV_READ_FAIL, 1'b1, 1'b1}, rdata);
    check_value("key_valid_o", 0, key_valid_o);
    check_value("key_o", 0, key_o);
    check_value("vault reads", fault_off[e] + 1, vault_acks - acks0);

    // Write lock while the engine is busy
    acks0         = vault_acks;
    engine_idle_i = 1'b0;
    write_reg(`KV_RD_CTRL_ADDR, {26'd0, 5'(pick_entry(1'b0)), 1'b1}, 1'b0);
    repeat (20) begin
      @(negedge clk);
      check_value("kv_req_o", 0, kv_req_o);
    end
    check_value("vault reads", 0, vault_acks - acks0);
    read_reg(`KV_RD_STATUS_ADDR, rdata);
    check_value("host_rdata_o", {22'd0, `KV_READ_FAIL, 1'b1, 1'b1}, rdata);
    read_reg(`KV_RD_CTRL_ADDR, rdata);
    check_value("host_rdata_o", {26'd0, 5'(e), 1'b0}, rdata);

    // Write lock during a fetch
    e2    = pick_entry(1'b0);
    acks0 = vault_acks;
    start_fetch(e2);
    write_reg(`KV_RD_CTRL_ADDR, {26'd0, 5'(e), 1'b1}, 1'b0);
    wait_fetch_done(rdata);
    check_value("host_rdata_o", {22'd0, `KV_SUCCESS, 1'b1, 1'b1}, rdata);
    check_value("key_o", expected_key(e2), key_o);
    check_value("vault reads", 8, vault_acks - acks0);
    read_reg(`KV_RD_CTRL_ADDR, rdata);
    check_value("host_rdata_o", {26'd0, 5'(e2), 1'b0}, rdata);

    repeat (4) @(negedge clk);
    if (u_dut.u_assertions.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule
